// ==== Bender.yml ====
package:
  name: inner_cross_bar

sources:
  - files:
      - hw/xbarPkg.sv
      - hw/memPort.sv
      - hw/fetchRouter.sv
      - hw/loadStoreRouter.sv
      - hw/periphArbiter.sv
      - hw/innerCrossBar.sv
  - target: test
    files:
      - verif/tbInnerCrossBar.sv

// ==== hw/fetchRouter.sv ====
// instruction fetch router
// steers IFU reads to the icache or to the peripheral path
// selects the 32 bit half of peripheral data by address bit 2

`timescale 1ns/1ps

module fetchRouter import xbarPkg::*; #(
	parameter addrT CacheBoundary = addrT'(64'h1_0000_0000)
) (
	input logic CLK,
	input logic reset,

	input logic icacheEnable,

	// IFU side
	input logic ifuReqValid,
	input addrT ifuAddr,
	output logic ifuReqReady,
	output logic ifuRspValid,
	output instrT ifuRdata,
	output respT ifuResp,
	input logic ifuRspReady,

	// icache side
	output logic icacheReqValid,
	input logic icacheReqReady,
	output addrT icacheAddr,
	input logic icacheRspValid,
	output logic icacheRspReady,
	input instrT icacheRdata,
	input respT icacheResp,

	// uncached path toward the arbiter
	memPort.master periph
);

	// one outstanding fetch
	logic busy;
	// target of the outstanding fetch, 1 for icache
	logic selCache;
	// word select for peripheral data
	logic addrBit2;

	// cacheable when enabled and in the upper region
	logic decodeCache;
	assign decodeCache = icacheEnable & (ifuAddr >= CacheBoundary);

	// request path, open only while idle
	assign icacheReqValid = ~busy & ifuReqValid & decodeCache;
	assign icacheAddr = ifuAddr;

	assign periph.reqValid = ~busy & ifuReqValid & ~decodeCache;
	assign periph.addr = ifuAddr;
	// fetches are always reads
	assign periph.write = 1'b0;
	assign periph.wdata = '0;
	assign periph.wstrb = '0;

	assign ifuReqReady = ~busy & (decodeCache ? icacheReqReady : periph.reqReady);

	// response path, steered by the recorded target
	assign ifuRspValid = busy & (selCache ? icacheRspValid : periph.rspValid);
	assign icacheRspReady = busy & selCache & ifuRspReady;
	assign periph.rspReady = busy & ~selCache & ifuRspReady;

	// upper or lower instruction of the 64 bit peripheral word
	assign ifuRdata = selCache ? icacheRdata :
		(addrBit2 ? periph.rdata[63:32] : periph.rdata[31:0]);
	assign ifuResp = selCache ? icacheResp : periph.resp;

	always_ff @(posedge CLK) begin
		if (reset) begin
			busy <= 1'b0;
			selCache <= 1'b0;
			addrBit2 <= 1'b0;
		end else if (!busy) begin
			// accept and remember where the fetch went
			if (ifuReqValid && ifuReqReady) begin
				busy <= 1'b1;
				selCache <= decodeCache;
				addrBit2 <= ifuAddr[2];
			end
		end else if (ifuRspValid && ifuRspReady) begin
			// response handed to the IFU, free again
			busy <= 1'b0;
		end
	end

endmodule

// ==== hw/innerCrossBar.sv ====
// inner crossbar top level
// fetch router, load/store router and peripheral arbiter
// joined through two memPort links

`timescale 1ns/1ps

module innerCrossBar import xbarPkg::*; #(
	// addresses at or above this are cacheable
	parameter addrT CacheBoundary = addrT'(64'h1_0000_0000)
) (
	input logic CLK,
	input logic reset,

	input logic icacheEnable,
	input logic dcacheEnable,

	// instruction fetch unit
	input logic ifuReqValid,
	output logic ifuReqReady,
	input addrT ifuAddr,
	output logic ifuRspValid,
	input logic ifuRspReady,
	output instrT ifuRdata,
	output respT ifuResp,

	// load/store unit
	input logic lsuReqValid,
	output logic lsuReqReady,
	input addrT lsuAddr,
	input logic lsuWrite,
	input dataT lsuWdata,
	input strbT lsuWstrb,
	output logic lsuRspValid,
	input logic lsuRspReady,
	output dataT lsuRdata,
	output respT lsuResp,

	// instruction cache
	output logic icacheReqValid,
	input logic icacheReqReady,
	output addrT icacheAddr,
	input logic icacheRspValid,
	output logic icacheRspReady,
	input instrT icacheRdata,
	input respT icacheResp,

	// data cache
	output logic dcacheReqValid,
	input logic dcacheReqReady,
	output addrT dcacheAddr,
	output logic dcacheWrite,
	output dataT dcacheWdata,
	output strbT dcacheWstrb,
	input logic dcacheRspValid,
	output logic dcacheRspReady,
	input dataT dcacheRdata,
	input respT dcacheResp,

	// shared peripheral bus
	output logic periphReqValid,
	input logic periphReqReady,
	output addrT periphAddr,
	output logic periphWrite,
	output dataT periphWdata,
	output strbT periphWstrb,
	input logic periphRspValid,
	output logic periphRspReady,
	input dataT periphRdata,
	input respT periphResp
);

	// uncached links into the arbiter
	memPort fetchToPeriph ();
	memPort lsuToPeriph ();

	fetchRouter #(
		.CacheBoundary(CacheBoundary)
	) fetchRouterInst (
		.CLK(CLK),
		.reset(reset),
		.icacheEnable(icacheEnable),
		.ifuReqValid(ifuReqValid),
		.ifuAddr(ifuAddr),
		.ifuReqReady(ifuReqReady),
		.ifuRspValid(ifuRspValid),
		.ifuRdata(ifuRdata),
		.ifuResp(ifuResp),
		.ifuRspReady(ifuRspReady),
		.icacheReqValid(icacheReqValid),
		.icacheReqReady(icacheReqReady),
		.icacheAddr(icacheAddr),
		.icacheRspValid(icacheRspValid),
		.icacheRspReady(icacheRspReady),
		.icacheRdata(icacheRdata),
		.icacheResp(icacheResp),
		.periph(fetchToPeriph.master)
	);

	loadStoreRouter #(
		.CacheBoundary(CacheBoundary)
	) loadStoreRouterInst (
		.CLK(CLK),
		.reset(reset),
		.dcacheEnable(dcacheEnable),
		.lsuReqValid(lsuReqValid),
		.lsuAddr(lsuAddr),
		.lsuWrite(lsuWrite),
		.lsuWdata(lsuWdata),
		.lsuWstrb(lsuWstrb),
		.lsuReqReady(lsuReqReady),
		.lsuRspValid(lsuRspValid),
		.lsuRdata(lsuRdata),
		.lsuResp(lsuResp),
		.lsuRspReady(lsuRspReady),
		.dcacheReqValid(dcacheReqValid),
		.dcacheReqReady(dcacheReqReady),
		.dcacheAddr(dcacheAddr),
		.dcacheWrite(dcacheWrite),
		.dcacheWdata(dcacheWdata),
		.dcacheWstrb(dcacheWstrb),
		.dcacheRspValid(dcacheRspValid),
		.dcacheRspReady(dcacheRspReady),
		.dcacheRdata(dcacheRdata),
		.dcacheResp(dcacheResp),
		.periph(lsuToPeriph.master)
	);

	periphArbiter periphArbiterInst (
		.CLK(CLK),
		.reset(reset),
		.fetchSide(fetchToPeriph.slave),
		.lsuSide(lsuToPeriph.slave),
		.periphReqValid(periphReqValid),
		.periphReqReady(periphReqReady),
		.periphAddr(periphAddr),
		.periphWrite(periphWrite),
		.periphWdata(periphWdata),
		.periphWstrb(periphWstrb),
		.periphRspValid(periphRspValid),
		.periphRspReady(periphRspReady),
		.periphRdata(periphRdata),
		.periphResp(periphResp)
	);

endmodule

// ==== hw/loadStoreRouter.sv ====
// load/store router
// steers LSU loads and stores to the dcache or to the peripheral path
// write data and strobes pass unchanged

`timescale 1ns/1ps

module loadStoreRouter import xbarPkg::*; #(
	parameter addrT CacheBoundary = addrT'(64'h1_0000_0000)
) (
	input logic CLK,
	input logic reset,

	input logic dcacheEnable,

	// LSU side
	input logic lsuReqValid,
	input addrT lsuAddr,
	input logic lsuWrite,
	input dataT lsuWdata,
	input strbT lsuWstrb,
	output logic lsuReqReady,
	output logic lsuRspValid,
	output dataT lsuRdata,
	output respT lsuResp,
	input logic lsuRspReady,

	// dcache side
	output logic dcacheReqValid,
	input logic dcacheReqReady,
	output addrT dcacheAddr,
	output logic dcacheWrite,
	output dataT dcacheWdata,
	output strbT dcacheWstrb,
	input logic dcacheRspValid,
	output logic dcacheRspReady,
	input dataT dcacheRdata,
	input respT dcacheResp,

	// uncached path toward the arbiter
	memPort.master periph
);

	// one outstanding access
	logic busy;
	// 1 when the outstanding access went to the dcache
	logic selCache;

	// same cacheable rule as the fetch side
	logic decodeCache;
	assign decodeCache = dcacheEnable & (lsuAddr >= CacheBoundary);

	// dcache request, payload straight from the LSU
	assign dcacheReqValid = ~busy & lsuReqValid & decodeCache;
	assign dcacheAddr = lsuAddr;
	assign dcacheWrite = lsuWrite;
	assign dcacheWdata = lsuWdata;
	assign dcacheWstrb = lsuWstrb;

	// peripheral request, same payload
	assign periph.reqValid = ~busy & lsuReqValid & ~decodeCache;
	assign periph.addr = lsuAddr;
	assign periph.write = lsuWrite;
	assign periph.wdata = lsuWdata;
	assign periph.wstrb = lsuWstrb;

	// ready from the decoded target, low while busy
	assign lsuReqReady = ~busy & (decodeCache ? dcacheReqReady : periph.reqReady);

	// response back from the recorded target only
	assign lsuRspValid = busy & (selCache ? dcacheRspValid : periph.rspValid);
	assign dcacheRspReady = busy & selCache & lsuRspReady;
	assign periph.rspReady = busy & ~selCache & lsuRspReady;

	assign lsuRdata = selCache ? dcacheRdata : periph.rdata;
	assign lsuResp = selCache ? dcacheResp : periph.resp;

	always_ff @(posedge CLK) begin
		if (reset) begin
			busy <= 1'b0;
			selCache <= 1'b0;
		end else if (!busy) begin
			// request accepted by its target
			if (lsuReqValid && lsuReqReady) begin
				busy <= 1'b1;
				selCache <= decodeCache;
			end
		end else if (lsuRspValid && lsuRspReady) begin
			// store ack or load data taken by the LSU
			busy <= 1'b0;
		end
	end

endmodule

// ==== hw/memPort.sv ====
// single-beat memory port
// one request channel and one response channel
// master and slave modports

`timescale 1ns/1ps

interface memPort import xbarPkg::*; ();

	// request channel
	logic reqValid;
	logic reqReady;
	addrT addr;
	logic write;
	dataT wdata;
	strbT wstrb;

	// response channel
	logic rspValid;
	logic rspReady;
	dataT rdata;
	respT resp;

	// request issuer
	modport master (
		output reqValid, addr, write, wdata, wstrb, rspReady,
		input reqReady, rspValid, rdata, resp
	);

	// request target
	modport slave (
		input reqValid, addr, write, wdata, wstrb, rspReady,
		output reqReady, rspValid, rdata, resp
	);

endinterface

// ==== hw/periphArbiter.sv ====
// peripheral arbiter
// round-robin between the fetch and load/store uncached paths
// one transaction at a time on the peripheral port
// response returned to the owning side only

`timescale 1ns/1ps

module periphArbiter import xbarPkg::*; (
	input logic CLK,
	input logic reset,

	// uncached traffic from the two routers
	memPort.slave fetchSide,
	memPort.slave lsuSide,

	// peripheral bus
	output logic periphReqValid,
	input logic periphReqReady,
	output addrT periphAddr,
	output logic periphWrite,
	output dataT periphWdata,
	output strbT periphWstrb,
	input logic periphRspValid,
	output logic periphRspReady,
	input dataT periphRdata,
	input respT periphResp
);

	arbStateT state;

	// round-robin priority, 0 means fetch first
	logic priorityLsu;
	// side that owns the outstanding transaction
	logic ownerLsu;
	// grant frozen while a stalled request waits on the port
	logic grantLocked;
	logic lockedLsu;

	logic idle;
	logic grantLsu;
	logic reqFire;
	logic rspFire;

	assign idle = (state == arbIdle);

	// lsu wins when it holds priority or fetch is not asking
	// a stalled request keeps its grant so the port payload stays steady
	assign grantLsu = grantLocked ? lockedLsu :
		(lsuSide.reqValid & (priorityLsu | ~fetchSide.reqValid));

	// forward the granted side while idle
	assign periphReqValid = idle & (grantLsu ? lsuSide.reqValid : fetchSide.reqValid);
	assign periphAddr = grantLsu ? lsuSide.addr : fetchSide.addr;
	assign periphWrite = grantLsu ? lsuSide.write : fetchSide.write;
	assign periphWdata = grantLsu ? lsuSide.wdata : fetchSide.wdata;
	assign periphWstrb = grantLsu ? lsuSide.wstrb : fetchSide.wstrb;

	// side not granted sees ready low
	assign fetchSide.reqReady = idle & ~grantLsu & periphReqReady;
	assign lsuSide.reqReady = idle & grantLsu & periphReqReady;

	// response to the owner only
	assign fetchSide.rspValid = ~idle & ~ownerLsu & periphRspValid;
	assign lsuSide.rspValid = ~idle & ownerLsu & periphRspValid;
	assign fetchSide.rdata = periphRdata;
	assign lsuSide.rdata = periphRdata;
	assign fetchSide.resp = periphResp;
	assign lsuSide.resp = periphResp;
	assign periphRspReady = ~idle & (ownerLsu ? lsuSide.rspReady : fetchSide.rspReady);

	assign reqFire = periphReqValid & periphReqReady;
	assign rspFire = periphRspValid & periphRspReady;

	always_ff @(posedge CLK) begin
		if (reset) begin
			state <= arbIdle;
			priorityLsu <= 1'b0;
			ownerLsu <= 1'b0;
			grantLocked <= 1'b0;
			lockedLsu <= 1'b0;
		end else begin
			case (state)
				arbIdle: begin
					if (reqFire) begin
						// transaction handed to the bus
						state <= arbBusy;
						ownerLsu <= grantLsu;
						grantLocked <= 1'b0;
					end else if (periphReqValid) begin
						// port stalled, hold this grant
						grantLocked <= 1'b1;
						lockedLsu <= grantLsu;
					end
				end
				arbBusy: begin
					if (rspFire) begin
						state <= arbIdle;
						// other side goes first next time
						priorityLsu <= ~ownerLsu;
					end
				end
				default: begin
					state <= arbIdle;
				end
			endcase
		end
	end

endmodule

// ==== hw/xbarPkg.sv ====
// shared types of the inner crossbar
// vector typedefs for address, data, strobe, instruction and response
// state enum of the peripheral arbiter

package xbarPkg;

	// bus address, full 64 bit space
	typedef logic [63:0] addrT;

	// load/store and peripheral data word
	typedef logic [63:0] dataT;

	// one write strobe per data byte
	typedef logic [7:0] strbT;

	// fetched instruction word
	typedef logic [31:0] instrT;

	// response code
	// zero is okay, anything else an error
	// codes travel unchanged from slave to master
	typedef logic [1:0] respT;

	// peripheral arbiter states
	// arbIdle  request path open, granted side forwarded
	// arbBusy  one transaction outstanding on the peripheral port
	typedef enum logic {
		arbIdle,
		arbBusy
	} arbStateT;

endpackage

// ==== sim.f ====
hw/xbarPkg.sv
hw/memPort.sv
hw/fetchRouter.sv
hw/loadStoreRouter.sv
hw/periphArbiter.sv
hw/innerCrossBar.sv
verif/tbInnerCrossBar.sv

// ==== verif/tbInnerCrossBar.sv ====
// testbench for the inner crossbar
// icache, dcache and peripheral responder models with random latency
// reference functions for routing, read data and response codes
// compare process on both master response channels
// directed tests, concurrent traffic and a random run

`timescale 1ns/1ps

module tbInnerCrossBar import xbarPkg::*; ();

	localparam addrT Boundary = addrT'(64'h1_0000_0000);
	localparam int TagIcache = 1;
	localparam int TagDcache = 2;
	localparam int TagPeriph = 3;
	localparam int NumDirected = 20;
	localparam int NumRandom = 40;
	// about ten cycles per transaction plus reset and slack
	localparam int CycleLimit = (NumDirected + 2 * NumRandom) * 10 + 100;

	logic CLK = 1'b0;
	logic reset;
	logic icacheEnable, dcacheEnable;
	logic ifuReqValid, ifuReqReady, ifuRspValid, ifuRspReady;
	addrT ifuAddr;
	instrT ifuRdata;
	respT ifuResp;
	logic lsuReqValid, lsuReqReady, lsuWrite, lsuRspValid, lsuRspReady;
	addrT lsuAddr;
	dataT lsuWdata, lsuRdata;
	strbT lsuWstrb;
	respT lsuResp;
	logic icacheReqValid, icacheReqReady, icacheRspValid, icacheRspReady;
	addrT icacheAddr;
	instrT icacheRdata;
	respT icacheResp;
	logic dcacheReqValid, dcacheReqReady, dcacheWrite, dcacheRspValid, dcacheRspReady;
	addrT dcacheAddr;
	dataT dcacheWdata, dcacheRdata;
	strbT dcacheWstrb;
	respT dcacheResp;
	logic periphReqValid, periphReqReady, periphWrite, periphRspValid, periphRspReady;
	addrT periphAddr;
	dataT periphWdata, periphRdata;
	strbT periphWstrb;
	respT periphResp;

	// one LFSR state per consumer derived from the main seed
	logic [15:0] rngMain, rngIfu, rngLsu, rngIc, rngDc, rngPh, rngRdy;

	int numChecks = 0;
	int numErrors = 0;
	int errMark = 0;
	int testNum = 1;
	int cycles = 0;
	int ifuDone = 0;
	int lsuDone = 0;
	// requests seen by each target and the predicted counts
	int icacheCount = 0, dcacheCount = 0, periphCount = 0;
	int expIc = 0, expDc = 0, expPh = 0;
	// stores seen by the targets and the predicted number
	int writeCount = 0;
	int expWr = 0;
	// last store seen by any target
	addrT lastWrAddr;
	dataT lastWrData;
	strbT lastWrStrb;

	// expected responses in issue order
	instrT expInstrQ[$];
	respT expIfuRespQ[$];
	dataT expLsuDataQ[$];
	respT expLsuRespQ[$];
	logic expLsuLoadQ[$];

	innerCrossBar #(.CacheBoundary(Boundary)) dut (.*);

	always #50 CLK = ~CLK;

	// Galois LFSR with taps for a maximal 16 bit sequence
	function automatic logic [15:0] lfsrStep(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// one step per bit taken
	task automatic takeBits(inout logic [15:0] s, input int n, output logic [63:0] v);
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			v = {v[62:0], s[0]};
			s = lfsrStep(s);
		end
	endtask

	// reference model of the routing and the targets
	function automatic logic isCached(input logic en, input addrT a);
		return en && (a >= Boundary);
	endfunction

	// read data of a target
	// halves differ so the word select shows
	function automatic dataT expectData(input addrT a, input int tag);
		logic [31:0] lo;
		logic [31:0] hi;
		lo = a[31:0] ^ a[63:32] ^ (32'h5A5A_0F0F + 32'(tag));
		hi = ~a[31:0] ^ {8'(tag), 24'h3C_1D2E};
		return {hi, lo};
	endfunction

	// peripheral errors on address bit 12
	function automatic respT expectResp(input logic cached, input addrT a);
		return (!cached && a[12]) ? 2'd2 : 2'd0;
	endfunction

	task automatic checkInstr(input string name, input instrT got, input instrT exp);
		numChecks++;
		if (got !== exp) begin
			numErrors++;
			$display("ERR %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic checkData(input string name, input dataT got, input dataT exp);
		numChecks++;
		if (got !== exp) begin
			numErrors++;
			$display("ERR %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic checkAddr(input string name, input addrT got, input addrT exp);
		numChecks++;
		if (got !== exp) begin
			numErrors++;
			$display("ERR %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic checkResp(input string name, input respT got, input respT exp);
		numChecks++;
		if (got !== exp) begin
			numErrors++;
			$display("ERR %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic checkStrb(input string name, input strbT got, input strbT exp);
		numChecks++;
		if (got !== exp) begin
			numErrors++;
			$display("ERR %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic checkCount(input string name, input int got, input int exp);
		numChecks++;
		if (got != exp) begin
			numErrors++;
			$display("ERR %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic reportFailure(input string msg);
		numErrors++;
		$display("%s", msg);
	endtask

	// one IFU fetch up to its response transfer
	task automatic fetch(input addrT a);
		dataT d;
		logic c;
		logic fire;
		int target;
		c = isCached(icacheEnable, a);
		d = expectData(a, c ? TagIcache : TagPeriph);
		expInstrQ.push_back(c ? d[31:0] : (a[2] ? d[63:32] : d[31:0]));
		expIfuRespQ.push_back(expectResp(c, a));
		if (c)
			expIc++;
		else
			expPh++;
		target = ifuDone + 1;
		ifuAddr = a;
		ifuReqValid = 1'b1;
		do begin
			@(posedge CLK);
			fire = ifuReqReady;
			#1;
		end while (!fire);
		ifuReqValid = 1'b0;
		while (ifuDone != target) begin
			@(posedge CLK);
			#1;
		end
	endtask

	// one LSU load or store
	// stores checked at the target afterwards
	task automatic access(input addrT a, input logic wr, input dataT wd, input strbT ws);
		logic c;
		logic fire;
		int target;
		c = isCached(dcacheEnable, a);
		expLsuDataQ.push_back(expectData(a, c ? TagDcache : TagPeriph));
		expLsuRespQ.push_back(expectResp(c, a));
		expLsuLoadQ.push_back(!wr);
		if (c)
			expDc++;
		else
			expPh++;
		if (wr)
			expWr++;
		target = lsuDone + 1;
		lsuAddr = a;
		lsuWrite = wr;
		lsuWdata = wd;
		lsuWstrb = ws;
		lsuReqValid = 1'b1;
		do begin
			@(posedge CLK);
			fire = lsuReqReady;
			#1;
		end while (!fire);
		lsuReqValid = 1'b0;
		while (lsuDone != target) begin
			@(posedge CLK);
			#1;
		end
		if (wr) begin
			checkAddr("storeAddr", lastWrAddr, a);
			checkData("storeData", lastWrData, wd);
			checkStrb("storeStrb", lastWrStrb, ws);
		end
	endtask

	// routing and write counts before the per test line
	task automatic endTest(input string name);
		checkCount("icacheCount", icacheCount, expIc);
		checkCount("dcacheCount", dcacheCount, expDc);
		checkCount("periphCount", periphCount, expPh);
		checkCount("writeCount", writeCount, expWr);
		$display("test %0d %s finished with %0d errors", testNum, name, numErrors - errMark);
		testNum++;
		errMark = numErrors;
		icacheCount = 0;
		dcacheCount = 0;
		periphCount = 0;
		writeCount = 0;
		expIc = 0;
		expDc = 0;
		expPh = 0;
		expWr = 0;
	endtask

	// compare process on both response channels
	always @(posedge CLK) begin : compareResponses
		logic isLoad;
		dataT ed;
		if (!reset && ifuRspValid && ifuRspReady) begin
			if (expInstrQ.size() == 0) begin
				reportFailure("ifu response arrived with no fetch outstanding");
			end else begin
				checkInstr("ifuRdata", ifuRdata, expInstrQ.pop_front());
				checkResp("ifuResp", ifuResp, expIfuRespQ.pop_front());
				ifuDone++;
			end
		end
		if (!reset && lsuRspValid && lsuRspReady) begin
			if (expLsuRespQ.size() == 0) begin
				reportFailure("lsu response arrived with no access outstanding");
			end else begin
				isLoad = expLsuLoadQ.pop_front();
				ed = expLsuDataQ.pop_front();
				if (isLoad)
					checkData("lsuRdata", lsuRdata, ed);
				checkResp("lsuResp", lsuResp, expLsuRespQ.pop_front());
				lsuDone++;
			end
		end
	end

	// random back-pressure on both masters
	always @(posedge CLK) begin : readyShaper
		logic [63:0] r;
		#1;
		takeBits(rngRdy, 2, r);
		ifuRspReady = r[0];
		lsuRspReady = r[1];
	end

	// icache model with 0 to 3 extra cycles of latency
	initial begin : icacheModel
		logic [63:0] r;
		dataT d;
		logic fire;
		forever begin
			@(posedge CLK);
			if (icacheReqValid && icacheReqReady) begin
				d = expectData(icacheAddr, TagIcache);
				icacheCount++;
				#1;
				icacheReqReady = 1'b0;
				takeBits(rngIc, 2, r);
				repeat (r[1:0]) begin
					@(posedge CLK);
					#1;
				end
				icacheRspValid = 1'b1;
				icacheRdata = d[31:0];
				icacheResp = 2'd0;
				do begin
					@(posedge CLK);
					fire = icacheRspReady;
					#1;
				end while (!fire);
				icacheRspValid = 1'b0;
			end else begin
				#1;
			end
			takeBits(rngIc, 1, r);
			icacheReqReady = r[0];
		end
	end

	// dcache model recording stores
	initial begin : dcacheModel
		logic [63:0] r;
		dataT d;
		logic fire;
		forever begin
			@(posedge CLK);
			if (dcacheReqValid && dcacheReqReady) begin
				d = expectData(dcacheAddr, TagDcache);
				if (dcacheWrite) begin
					lastWrAddr = dcacheAddr;
					lastWrData = dcacheWdata;
					lastWrStrb = dcacheWstrb;
					writeCount++;
				end
				dcacheCount++;
				#1;
				dcacheReqReady = 1'b0;
				takeBits(rngDc, 2, r);
				repeat (r[1:0]) begin
					@(posedge CLK);
					#1;
				end
				dcacheRspValid = 1'b1;
				dcacheRdata = d;
				dcacheResp = 2'd0;
				do begin
					@(posedge CLK);
					fire = dcacheRspReady;
					#1;
				end while (!fire);
				dcacheRspValid = 1'b0;
			end else begin
				#1;
			end
			takeBits(rngDc, 1, r);
			dcacheReqReady = r[0];
		end
	end

	// peripheral model
	// also watches for a second request while busy
	initial begin : periphModel
		logic [63:0] r;
		dataT d;
		logic fire;
		respT code;
		forever begin
			@(posedge CLK);
			if (periphReqValid && periphReqReady) begin
				d = expectData(periphAddr, TagPeriph);
				code = periphAddr[12] ? 2'd2 : 2'd0;
				if (periphWrite) begin
					lastWrAddr = periphAddr;
					lastWrData = periphWdata;
					lastWrStrb = periphWstrb;
					writeCount++;
				end
				periphCount++;
				#1;
				periphReqReady = 1'b0;
				takeBits(rngPh, 2, r);
				repeat (r[1:0]) begin
					@(posedge CLK);
					if (periphReqValid)
						reportFailure("peripheral saw a new request before the response");
					#1;
				end
				periphRspValid = 1'b1;
				periphRdata = d;
				periphResp = code;
				do begin
					@(posedge CLK);
					fire = periphRspReady;
					if (periphReqValid)
						reportFailure("peripheral saw a new request before the response");
					#1;
				end while (!fire);
				periphRspValid = 1'b0;
			end else begin
				#1;
			end
			takeBits(rngPh, 1, r);
			periphReqReady = r[0];
		end
	end

	// cycle limit
	always @(posedge CLK) begin
		cycles++;
		if (cycles > CycleLimit) begin
			$display("timeout after %0d cycles, run did not complete", cycles);
			$display("TESTS FAILED");
			$finish;
		end
	end

	initial begin : mainSequence
		logic [63:0] v;
		logic [63:0] vf;
		logic [63:0] vl;
		addrT a;
		int i;
		int j;
		// every DUT input at time zero
		reset = 1'b1;
		icacheEnable = 1'b1;
		dcacheEnable = 1'b1;
		ifuReqValid = 1'b0;
		ifuAddr = '0;
		ifuRspReady = 1'b0;
		lsuReqValid = 1'b0;
		lsuAddr = '0;
		lsuWrite = 1'b0;
		lsuWdata = '0;
		lsuWstrb = '0;
		lsuRspReady = 1'b0;
		icacheReqReady = 1'b1;
		icacheRspValid = 1'b0;
		icacheRdata = '0;
		icacheResp = '0;
		dcacheReqReady = 1'b1;
		dcacheRspValid = 1'b0;
		dcacheRdata = '0;
		dcacheResp = '0;
		periphReqReady = 1'b1;
		periphRspValid = 1'b0;
		periphRdata = '0;
		periphResp = '0;
		// split the seed into independent streams
		rngMain = 16'd59790;
		takeBits(rngMain, 16, v);
		rngIfu = v[15:0] | 16'h1;
		takeBits(rngMain, 16, v);
		rngLsu = v[15:0] | 16'h1;
		takeBits(rngMain, 16, v);
		rngIc = v[15:0] | 16'h1;
		takeBits(rngMain, 16, v);
		rngDc = v[15:0] | 16'h1;
		takeBits(rngMain, 16, v);
		rngPh = v[15:0] | 16'h1;
		takeBits(rngMain, 16, v);
		rngRdy = v[15:0] | 16'h1;

		repeat (3) @(posedge CLK);
		#1;
		reset = 1'b0;

		// cached fetches then enable off then below the boundary
		fetch(Boundary + 64'h100);
		fetch(Boundary + 64'h2004);
		icacheEnable = 1'b0;
		fetch(Boundary + 64'h100);
		icacheEnable = 1'b1;
		fetch(64'h800);
		endTest("fetch routing");

		// both halves of one peripheral word
		fetch(64'h1000_0000);
		fetch(64'h1000_0004);
		endTest("fetch word select");

		fetch(64'h0);
		access(Boundary + 64'h40, 1'b1, 64'h0123_4567_89AB_CDEF, 8'hF0);
		access(Boundary + 64'h40, 1'b0, '0, '0);
		access(64'h300, 1'b1, 64'hFEDC_BA98_7654_3210, 8'h0F);
		access(64'h300, 1'b0, '0, '0);
		dcacheEnable = 1'b0;
		access(Boundary + 64'h80, 1'b1, 64'hA5A5_5A5A_C3C3_3C3C, 8'h3C);
		access(Boundary + 64'h80, 1'b0, '0, '0);
		dcacheEnable = 1'b1;
		endTest("load store routing");

		// both masters on the peripheral at once
		fork
			fetch(64'h2000_0008);
			access(64'h2000_0010, 1'b0, '0, '0);
		join
		fork
			fetch(64'h40);
			access(64'h48, 1'b1, 64'h1111_2222_3333_4444, 8'hFF);
		join
		endTest("concurrent uncached");

		// random addresses on both masters in parallel
		fork
			begin
				for (i = 0; i < NumRandom; i++) begin
					takeBits(rngIfu, 33, vf);
					a = addrT'(vf[32:0]);
					a[1:0] = 2'b00;
					fetch(a);
				end
			end
			begin
				for (j = 0; j < NumRandom; j++) begin
					takeBits(rngLsu, 33, vl);
					a = addrT'(vl[32:0]);
					a[2:0] = 3'b000;
					takeBits(rngLsu, 64, v);
					takeBits(rngLsu, 9, vl);
					access(a, vl[8], v, vl[7:0]);
				end
			end
		join
		endTest("random traffic");

		// error code goes to the owner only
		fork
			fetch(64'h1004);
			access(64'h40, 1'b0, '0, '0);
		join
		fork
			fetch(64'h44);
			access(64'h3000, 1'b0, '0, '0);
		join
		endTest("error response");

		$display("checks %0d, errors %0d", numChecks, numErrors);
		if (numErrors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule
